// File: Makefile
# Verilator build and run of the keyboard controller testbench

TOP := tb_keyboard_controller

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check for the pass line"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
		--top-module $(TOP) -f all.f -o sim
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

// File: all.f
+incdir+design
design/ps2_pkg.sv
design/kbd_reg_pkg.sv
design/ps2_frame_rx.sv
design/scan_fifo.sv
design/kbd_regs.sv
design/keyboard_controller.sv
bench/tb_clock.sv
bench/tb_keyboard_controller.sv

// File: bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic reset
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reset high for the first ten rising edges
    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// File: bench/tb_keyboard_controller.sv
`timescale 1ns/1ps
`include "kbd_defines.svh"

module tb_keyboard_controller;

    // ======================================================================
    // Run length and register map
    // ======================================================================
    localparam int frames_sent     = 17;          // Full and partial frames over all tests
    localparam int frame_cycles    = 11 * 16 + 20;
    localparam int watchdog_cycles =
        (frames_sent * frame_cycles + 2 * `KBD_TIMEOUT_CYCLES) * 11 / 10;

    localparam logic [3:0] off_ascii   = 4'h0;   // Unmapped now
    localparam logic [3:0] off_raw     = 4'h1;
    localparam logic [3:0] off_status  = 4'h2;
    localparam logic [3:0] off_control = 4'h3;

    logic                     clk;
    logic                     reset;
    logic                     device_select;
    logic [`KBD_OFFSET_W-1:0] register_offset;
    logic                     read_req;
    logic                     write_req;
    logic [`KBD_BUS_W-1:0]    wdata;
    logic [`KBD_BUS_W-1:0]    rdata;
    logic                     ps2_clk;
    logic                     ps2_data;

    int          errors;
    int          checks;
    logic [31:0] rng_state;
    logic [7:0]  codes [$];   // Expected FIFO order

    tb_clock i_clock (
        .clk   (clk),
        .reset (reset)
    );

    keyboard_controller i_dut (
        .clk             (clk),
        .reset           (reset),
        .device_select   (device_select),
        .register_offset (register_offset),
        .read_req        (read_req),
        .write_req       (write_req),
        .wdata           (wdata),
        .rdata           (rdata),
        .ps2_clk         (ps2_clk),
        .ps2_data        (ps2_data)
    );

    // LCG step with the scan code taken from the middle bits
    function automatic logic [7:0] random_code();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state[23:16];
    endfunction

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("ERROR at %0t ns: %s = 0x%04h, expected 0x%04h",
                     $time, name, got, expected);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // ======================================================================
    // PS/2 line driver with 8 clocks per half period
    // ======================================================================
    task automatic drive_bit(input logic value);
        repeat (4) @(posedge clk);
        ps2_data <= value;        // Data moves while the clock is high
        repeat (4) @(posedge clk);
        ps2_clk <= 1'b0;          // Receiver samples on this fall
        repeat (8) @(posedge clk);
        ps2_clk <= 1'b1;
    endtask

    task automatic send_frame(input logic [7:0] code, input logic bad_parity,
                              input logic bad_stop);
        logic parity;
        int   i;
        parity = ~(^code) ^ bad_parity;   // Odd over data and parity
        drive_bit(1'b0);                  // Start
        for (i = 0; i < 8; i++) begin
            drive_bit(code[i]);           // LSB first
        end
        drive_bit(parity);
        drive_bit(!bad_stop);
        repeat (4) @(posedge clk);
        ps2_data <= 1'b1;                 // Idle again
    endtask

    // ======================================================================
    // One-cycle bus accesses
    // ======================================================================
    task automatic bus_read(input logic [3:0] offset, output logic [15:0] data);
        @(posedge clk);
        device_select   <= 1'b1;
        read_req        <= 1'b1;
        register_offset <= offset;
        @(negedge clk);
        data = rdata;             // Settled by mid-cycle
        @(posedge clk);
        device_select <= 1'b0;
        read_req      <= 1'b0;
    endtask

    task automatic bus_write(input logic [3:0] offset, input logic [15:0] data);
        @(posedge clk);
        device_select   <= 1'b1;
        write_req       <= 1'b1;
        register_offset <= offset;
        wdata           <= data;
        @(posedge clk);
        device_select <= 1'b0;
        write_req     <= 1'b0;
        wdata         <= '0;
    endtask

    task automatic read_check(input logic [3:0] offset, input logic [15:0] expected,
                              input string name);
        logic [15:0] data;
        bus_read(offset, data);
        check_value(name, data, expected);
    endtask

    // ======================================================================
    // Directed tests
    // ======================================================================
    task automatic reset_state_reads();
        int off;
        read_check(off_status, 16'h0000, "rdata(status)");
        read_check(off_raw, 16'h0000, "rdata(raw)");
        read_check(off_control, 16'h0000, "rdata(control)");
        read_check(off_ascii, 16'hffff, "rdata(offset 0)");
        for (off = 4; off < 16; off++) begin
            read_check(off[3:0], 16'hffff, "rdata(unmapped)");
        end
    endtask

    task automatic single_frame();
        logic [7:0] code;
        code = random_code();
        send_frame(code, 1'b0, 1'b0);
        wait_cycles(20);
        read_check(off_status, 16'h0001, "rdata(status)");   // Available only
        read_check(off_raw, {8'h00, code}, "rdata(raw)");
        read_check(off_raw, 16'h0000, "rdata(raw empty)");
        read_check(off_status, 16'h0000, "rdata(status)");
    endtask

    task automatic rejected_frames();
        send_frame(random_code(), 1'b1, 1'b0);   // Wrong parity
        wait_cycles(20);
        read_check(off_status, 16'h0000, "rdata(status after parity error)");
        send_frame(random_code(), 1'b0, 1'b1);   // Stop bit low
        wait_cycles(20);
        read_check(off_status, 16'h0000, "rdata(status after stop error)");
    endtask

    task automatic overflow_and_drain();
        logic [7:0] code;
        int         i;
        codes.delete();
        for (i = 0; i < `KBD_FIFO_DEPTH + 1; i++) begin
            code = random_code();
            codes.push_back(code);   // Ninth one gets dropped
            send_frame(code, 1'b0, 1'b0);
        end
        wait_cycles(20);
        read_check(off_status, 16'h0007, "rdata(status full)");
        for (i = 0; i < `KBD_FIFO_DEPTH; i++) begin
            read_check(off_raw, {8'h00, codes[i]}, "rdata(raw)");
            if (i == 0) begin
                read_check(off_status, 16'h0001, "rdata(status after pop)");
            end
        end
        read_check(off_status, 16'h0000, "rdata(status drained)");
    endtask

    task automatic control_clear();
        int i;
        for (i = 0; i < 3; i++) begin
            send_frame(random_code(), 1'b0, 1'b0);
        end
        wait_cycles(20);
        bus_write(off_control, 16'h0001);
        wait_cycles(3);
        read_check(off_status, 16'h0000, "rdata(status after clear)");
        read_check(off_raw, 16'h0000, "rdata(raw after clear)");
    endtask

    task automatic stalled_frame_recovery();
        logic [7:0] code;
        int         i;
        code = random_code();
        drive_bit(1'b0);                 // Start bit and half a byte
        for (i = 0; i < 4; i++) begin
            drive_bit(code[i]);
        end
        ps2_data <= 1'b1;
        wait_cycles(`KBD_TIMEOUT_CYCLES + 20);
        code = random_code();
        send_frame(code, 1'b0, 1'b0);    // Needs a receiver back in idle
        wait_cycles(20);
        read_check(off_status, 16'h0001, "rdata(status after timeout)");
        read_check(off_raw, {8'h00, code}, "rdata(raw after timeout)");
        read_check(off_status, 16'h0000, "rdata(status)");
    endtask

    // ======================================================================
    // Main sequence and watchdog
    // ======================================================================
    initial begin
        errors          = 0;
        checks          = 0;
        rng_state       = 32'hd9d8e192;
        device_select   = 1'b0;
        register_offset = '0;
        read_req        = 1'b0;
        write_req       = 1'b0;
        wdata           = '0;
        ps2_clk         = 1'b1;   // PS/2 lines idle high
        ps2_data        = 1'b1;
        @(negedge reset);
        @(posedge clk);
        reset_state_reads();
        single_frame();
        rejected_frames();
        overflow_and_drain();
        control_clear();
        stalled_frame_recovery();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles and the tests did not finish",
                 watchdog_cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: design/kbd_defines.svh
`ifndef KBD_DEFINES_SVH
`define KBD_DEFINES_SVH

// ======================================================================
// Keyboard controller sizing
// ======================================================================

// Scan-code FIFO entries
`define KBD_FIFO_DEPTH      8

// Widths on the line side and the bus side
`define KBD_BYTE_W          8    // One scan code
`define KBD_BUS_W           16   // I/O bus data
`define KBD_OFFSET_W        4    // Register offset

// Idle clocks between PS/2 edges before a partial frame is dropped
`define KBD_TIMEOUT_CYCLES  10000  // 100 us at 100 MHz

`endif

// File: design/kbd_reg_pkg.sv
`include "kbd_defines.svh"

// ======================================================================
// Bus-side types of the keyboard register block
// ======================================================================
package kbd_reg_pkg;

    // Register offsets
    typedef enum logic [`KBD_OFFSET_W-1:0] {
        reg_ascii   = 4'h0,  // Former ASCII port, unmapped now
        reg_raw     = 4'h1,  // Raw scan code, pops on read
        reg_status  = 4'h2,  // FIFO status
        reg_control = 4'h3   // Bit 0 clears the FIFO
    } kbd_reg_e;

    // One bus cycle as seen by the register block
    typedef struct packed {
        logic                  select;  // Device select
        logic                  read;    // Read request
        logic                  write;   // Write request
        kbd_reg_e              offset;
        logic [`KBD_BUS_W-1:0] wdata;
    } kbd_bus_req_t;

    // FIFO flags, bit order matches the status word
    typedef struct packed {
        logic overflow;   // Bit 2, sticky until a pop
        logic full;       // Bit 1
        logic available;  // Bit 0
    } fifo_status_t;

    // Status register layout
    typedef struct packed {
        logic [`KBD_BUS_W-4:0] reserved;  // Reads zero
        fifo_status_t          fifo;
    } kbd_status_t;

endpackage

// File: design/kbd_regs.sv
`timescale 1ns/1ps
`include "kbd_defines.svh"

module kbd_regs (
    input  logic                      clk,
    input  logic                      reset,
    input  kbd_reg_pkg::kbd_bus_req_t req,
    input  logic [`KBD_BYTE_W-1:0]    head,         // FIFO head byte
    input  kbd_reg_pkg::fifo_status_t fifo_status,
    output logic                      pop,          // One-cycle FIFO read
    output logic                      clear,        // One-cycle FIFO clear
    output logic [`KBD_BUS_W-1:0]     rdata
);

    kbd_reg_pkg::kbd_status_t status_word;
    logic                     rd_hit;
    logic                     ctrl_wr;

    assign rd_hit  = req.select && req.read;
    assign ctrl_wr = req.select && req.write && (req.offset == kbd_reg_pkg::reg_control);

    // Raw read pops only a non-empty FIFO
    assign pop = rd_hit && (req.offset == kbd_reg_pkg::reg_raw) && fifo_status.available;

    // ==================================================================
    // Control register, write only
    // ==================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            clear <= 1'b0;
        end else begin
            clear <= ctrl_wr && req.wdata[0];  // Strobe, drops next cycle
        end
    end

    // Status word, upper bits zero
    assign status_word.reserved = '0;
    assign status_word.fifo     = fifo_status;

    // ==================================================================
    // Read mux, zero when idle
    // ==================================================================
    always_comb begin
        rdata = '0;
        if (rd_hit) begin
            case (req.offset)
                kbd_reg_pkg::reg_raw: begin
                    if (fifo_status.available) begin
                        rdata = {{(`KBD_BUS_W - `KBD_BYTE_W){1'b0}}, head};
                    end
                end
                kbd_reg_pkg::reg_status:  rdata = status_word;
                kbd_reg_pkg::reg_control: rdata = '0;  // Write only
                kbd_reg_pkg::reg_ascii:   rdata = '1;  // No ASCII path
                default:                  rdata = '1;  // Unmapped
            endcase
        end
    end

endmodule

// File: design/keyboard_controller.sv
`timescale 1ns/1ps
`include "kbd_defines.svh"

module keyboard_controller (
    input  logic                     clk,
    input  logic                     reset,
    // I/O bus
    input  logic                     device_select,
    input  logic [`KBD_OFFSET_W-1:0] register_offset,
    input  logic                     read_req,
    input  logic                     write_req,
    input  logic [`KBD_BUS_W-1:0]    wdata,
    output logic [`KBD_BUS_W-1:0]    rdata,
    // PS/2 lines
    input  logic                     ps2_clk,
    input  logic                     ps2_data
);

    // ==================================================================
    // Receiver, FIFO and register block in a chain
    // ==================================================================
    kbd_reg_pkg::kbd_bus_req_t req;
    ps2_pkg::scan_byte_t       scan;         // Receiver to FIFO
    logic [`KBD_BYTE_W-1:0]    head;
    kbd_reg_pkg::fifo_status_t fifo_status;
    logic                      pop;
    logic                      clear;

    // Bus ports into one request
    assign req.select = device_select;
    assign req.read   = read_req;
    assign req.write  = write_req;
    assign req.offset = kbd_reg_pkg::kbd_reg_e'(register_offset);
    assign req.wdata  = wdata;

    ps2_frame_rx i_rx (
        .clk      (clk),
        .reset    (reset),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .scan     (scan)
    );

    scan_fifo i_fifo (
        .clk    (clk),
        .reset  (reset),
        .scan   (scan),
        .pop    (pop),
        .clear  (clear),
        .head   (head),
        .status (fifo_status)
    );

    kbd_regs i_regs (
        .clk         (clk),
        .reset       (reset),
        .req         (req),
        .head        (head),
        .fifo_status (fifo_status),
        .pop         (pop),
        .clear       (clear),
        .rdata       (rdata)
    );

endmodule

// File: design/ps2_frame_rx.sv
`timescale 1ns/1ps
`include "kbd_defines.svh"

module ps2_frame_rx (
    input  logic                clk,
    input  logic                reset,
    input  logic                ps2_clk,   // From keyboard, asynchronous
    input  logic                ps2_data,  // From keyboard, asynchronous
    output ps2_pkg::scan_byte_t scan       // To scan FIFO
);

    localparam int unsigned timeout_w = $clog2(`KBD_TIMEOUT_CYCLES);

    // Synchronizers, three flops per line
    logic [2:0] clk_sync;
    logic [2:0] data_sync;
    logic       clk_fall;
    logic       data_bit;   // Sampled line value

    // Frame decoder
    ps2_pkg::ps2_state_e     state;
    ps2_pkg::ps2_state_e     next_state;
    logic [2:0]              bit_idx;      // Data bit position
    logic [`KBD_BYTE_W-1:0]  shift_reg;    // Bits shift in from the top
    logic                    parity_bit;
    logic                    stop_bit;
    logic [timeout_w-1:0]    timeout_cnt;  // Clocks since last edge
    logic                    timed_out;
    logic                    frame_ok;
    logic                    scan_valid;

    // ==================================================================
    // Line synchronization and edge detection
    // ==================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            clk_sync  <= 3'b111;  // Lines idle high
            data_sync <= 3'b111;
        end else begin
            clk_sync  <= {clk_sync[1:0], ps2_clk};
            data_sync <= {data_sync[1:0], ps2_data};
        end
    end

    assign clk_fall = clk_sync[2] && !clk_sync[1];  // High then low
    assign data_bit = data_sync[2];

    // ==================================================================
    // Frame state machine
    // ==================================================================
    assign timed_out = (timeout_cnt == timeout_w'(`KBD_TIMEOUT_CYCLES - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ps2_pkg::rx_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ps2_pkg::rx_idle: begin
                if (clk_fall && !data_bit) begin  // Start bit is low
                    next_state = ps2_pkg::rx_start;
                end
            end
            ps2_pkg::rx_start:    next_state = ps2_pkg::rx_data;
            ps2_pkg::rx_data: begin
                if (clk_fall && (bit_idx == 3'd7)) begin
                    next_state = ps2_pkg::rx_parity;
                end else if (timed_out) begin
                    next_state = ps2_pkg::rx_idle;  // Stalled frame
                end
            end
            ps2_pkg::rx_parity: begin
                if (clk_fall) next_state = ps2_pkg::rx_stop;
                else if (timed_out) next_state = ps2_pkg::rx_idle;
            end
            ps2_pkg::rx_stop: begin
                if (clk_fall) next_state = ps2_pkg::rx_validate;
                else if (timed_out) next_state = ps2_pkg::rx_idle;
            end
            ps2_pkg::rx_validate: next_state = ps2_pkg::rx_idle;  // Single cycle
            default:              next_state = ps2_pkg::rx_idle;
        endcase
    end

    // Bit index, timeout and strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            bit_idx     <= 3'd0;
            timeout_cnt <= '0;
            scan_valid  <= 1'b0;
        end else begin
            scan_valid <= (state == ps2_pkg::rx_validate) && frame_ok;
            case (state)
                ps2_pkg::rx_data, ps2_pkg::rx_parity, ps2_pkg::rx_stop: begin
                    timeout_cnt <= clk_fall ? '0 : timeout_cnt + 1'b1;
                end
                default: timeout_cnt <= '0;  // Not inside a frame
            endcase
            if (state == ps2_pkg::rx_data) begin
                if (clk_fall) bit_idx <= bit_idx + 3'd1;
            end else begin
                bit_idx <= 3'd0;
            end
        end
    end

    // Payload capture
    always_ff @(posedge clk) begin
        if (clk_fall) begin
            case (state)
                ps2_pkg::rx_data:   shift_reg  <= {data_bit, shift_reg[7:1]};  // LSB first
                ps2_pkg::rx_parity: parity_bit <= data_bit;
                ps2_pkg::rx_stop:   stop_bit   <= data_bit;
                default: ;
            endcase
        end
    end

    // Odd parity over data plus parity, stop must be high
    assign frame_ok = stop_bit && (^{shift_reg, parity_bit});

    assign scan.valid = scan_valid;
    assign scan.code  = shift_reg;  // Held until the next frame

endmodule

// File: design/ps2_pkg.sv
`include "kbd_defines.svh"

// ======================================================================
// PS/2 line-side types
// ======================================================================
package ps2_pkg;

    // Frame receiver states, one data state walks all eight bits
    typedef enum logic [3:0] {
        rx_idle,      // Waiting for start bit
        rx_start,     // Start bit seen
        rx_data,      // Eight data bits, LSB first
        rx_parity,    // Odd parity bit
        rx_stop,      // Stop bit
        rx_validate   // One cycle of frame check
    } ps2_state_e;

    // Received byte with its write strobe
    typedef struct packed {
        logic                   valid;  // One-cycle strobe
        logic [`KBD_BYTE_W-1:0] code;   // Scan code
    } scan_byte_t;

endpackage

// File: design/scan_fifo.sv
`timescale 1ns/1ps
`include "kbd_defines.svh"

module scan_fifo (
    input  logic                     clk,
    input  logic                     reset,
    input  ps2_pkg::scan_byte_t      scan,    // Write strobe and byte
    input  logic                     pop,     // Already gated by available
    input  logic                     clear,   // Empties the FIFO
    output logic [`KBD_BYTE_W-1:0]   head,
    output kbd_reg_pkg::fifo_status_t status
);

    localparam int unsigned ptr_w = $clog2(`KBD_FIFO_DEPTH);
    localparam int unsigned cnt_w = $clog2(`KBD_FIFO_DEPTH + 1);

    logic [`KBD_BYTE_W-1:0] mem [`KBD_FIFO_DEPTH];
    logic [ptr_w-1:0]       wr_ptr;
    logic [ptr_w-1:0]       rd_ptr;
    logic [cnt_w-1:0]       count;     // 0 to depth
    logic                   full;
    logic                   overflow;  // Sticky on dropped write
    logic                   mem_wr;

    assign full   = (count == cnt_w'(`KBD_FIFO_DEPTH));
    assign mem_wr = scan.valid && (pop || !full);  // Pop frees the slot

    // Storage
    always_ff @(posedge clk) begin
        if (mem_wr) begin
            mem[wr_ptr] <= scan.code;
        end
    end

    // ==================================================================
    // Pointers, count and overflow
    // ==================================================================
    always_ff @(posedge clk) begin
        if (reset || clear) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else if (scan.valid && pop) begin
            wr_ptr <= wr_ptr + 1'b1;  // Count and overflow unchanged
            rd_ptr <= rd_ptr + 1'b1;
        end else if (scan.valid && !full) begin
            wr_ptr <= wr_ptr + 1'b1;
            count  <= count + 1'b1;
        end else if (scan.valid) begin
            overflow <= 1'b1;         // Full so the byte is dropped
        end else if (pop) begin
            rd_ptr   <= rd_ptr + 1'b1;
            count    <= count - 1'b1;
            overflow <= 1'b0;         // Room again
        end
    end

    assign head             = mem[rd_ptr];
    assign status.available = (count != '0);
    assign status.full      = full;
    assign status.overflow  = overflow;

endmodule
